/* Makefile */
# Verilator build and run of the system controller testbench

VERILATOR ?= verilator
TOP       ?= sysctl_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SEED      ?= 0
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: test clean help

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for failure"
	@echo "  clean  remove build outputs and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG SEED VFLAGS"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-$(SIM) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/sysctl_props.sv */
/* Concurrent checks on the sysctl_top ports, attached with bind.
   The default region starts right after the boot loader region. */
`timescale 1ns/1ps

module sysctl_props (
	input logic                          clk48mhz_i,
	input logic                          rst_p,
	input pi1_pkg::pi1_op_t              op_i,
	input logic [pi1_pkg::ADDRBITSZ-1:0] addr_i,
	input logic                          rdy_o,
	input pi1_pkg::pi1_op_t              ext_op_o,
	input logic                          sys_rst_o
);

	function automatic logic [pi1_pkg::ADDRBITSZ:0] default_base();
		logic [pi1_pkg::ADDRBITSZ:0] sum;
		sum = '0;
		for (int k = 0; k < int'(soc_map_pkg::S_INVALIDDEV); k++) begin
			sum = sum + {1'b0, soc_map_pkg::REGION_SIZE[k]};
		end
		return sum;
	endfunction

	localparam logic [pi1_pkg::ADDRBITSZ:0] DEFAULT_BASE = default_base();

	// Default slave answers without wait states
	a_default_rdy: assert property (@(posedge clk48mhz_i)
		(op_i != pi1_pkg::PI1_NOOP && {1'b0, addr_i} >= DEFAULT_BASE) |-> rdy_o)
		else $error("default slave did not answer in the same cycle");

	a_ext_idle: assert property (@(posedge clk48mhz_i)
		(sys_rst_o === 1'b1) |-> (ext_op_o == pi1_pkg::PI1_NOOP))
		else $error("external request issued during system reset");

	a_rst_follow: assert property (@(posedge clk48mhz_i) rst_p |=> sys_rst_o)
		else $error("system reset did not follow the reset button");

endmodule

bind sysctl_top sysctl_props u_props (
	.clk48mhz_i (clk48mhz_i),
	.rst_p      (rst_p),
	.op_i       (op_i),
	.addr_i     (addr_i),
	.rdy_o      (rdy_o),
	.ext_op_o   (ext_op_o),
	.sys_rst_o  (sys_rst_o)
);

/* testbench/sysctl_tb.sv */
/* Runs the steps in testbench/sysctl_tests.txt against sysctl_top with a 4-bit reset hold.
   The external slave answers idx<<28 | offset[27:0] after 0 to 3 extra cycles. */
`timescale 1ns/1ps

module sysctl_tb;

	localparam int MAX_STEPS   = 64;
	// Worst case per step, including a full reset hold
	localparam int STEP_CYCLES = 64;
	localparam int CLK_HALF    = 5;

	logic                                  clk48mhz_i;
	logic                                  rst_p;
	logic                                  pll_locked_i;
	logic                                  cpu_rst_i;
	pi1_pkg::pi1_op_t                      op_i;
	logic [pi1_pkg::ADDRBITSZ-1:0]         addr_i;
	logic [pi1_pkg::ARCHBITSZ-1:0]         data_i;
	logic [pi1_pkg::SELBITSZ-1:0]          sel_i;
	logic [pi1_pkg::ARCHBITSZ-1:0]         data_o;
	logic                                  rdy_o;
	pi1_pkg::pi1_op_t                      ext_op_o;
	logic [soc_map_pkg::SLAVEIDXBITSZ-1:0] ext_idx_o;
	logic [pi1_pkg::ADDRBITSZ-1:0]         ext_addr_o;
	logic [pi1_pkg::ARCHBITSZ-1:0]         ext_data_o;
	logic [pi1_pkg::SELBITSZ-1:0]          ext_sel_o;
	logic [pi1_pkg::ARCHBITSZ-1:0]         ext_data_i = '0;
	logic                                  ext_rdy_i  = 1'b0;
	logic                                  sys_rst_o;

	// External slave model state
	logic        ext_busy = 1'b0;
	logic [1:0]  ext_wait = 2'd0;
	logic [31:0] ext_resp = '0;

	// Four words per step: kind, address, data, expected
	logic [31:0] steps [4*MAX_STEPS];
	int          nsteps;
	int          errors;
	bit          loaded = 1'b0;

	sysctl_top #(
		.RST_HOLD_BITS (4)
	) UUT (
		.clk48mhz_i   (clk48mhz_i),
		.rst_p        (rst_p),
		.pll_locked_i (pll_locked_i),
		.cpu_rst_i    (cpu_rst_i),
		.op_i         (op_i),
		.addr_i       (addr_i),
		.data_i       (data_i),
		.sel_i        (sel_i),
		.data_o       (data_o),
		.rdy_o        (rdy_o),
		.ext_op_o     (ext_op_o),
		.ext_idx_o    (ext_idx_o),
		.ext_addr_o   (ext_addr_o),
		.ext_data_o   (ext_data_o),
		.ext_sel_o    (ext_sel_o),
		.ext_data_i   (ext_data_i),
		.ext_rdy_i    (ext_rdy_i),
		.sys_rst_o    (sys_rst_o)
	);

	initial begin
		clk48mhz_i = 1'b0;
		forever #CLK_HALF clk48mhz_i = ~clk48mhz_i;
	end

	// Request seen at a rising edge, answer driven on a falling edge
	always @(posedge clk48mhz_i) begin
		if (ext_rdy_i) begin
			ext_busy <= 1'b0;
		end else if (ext_busy) begin
			if (ext_wait != 2'd0) begin
				ext_wait <= ext_wait - 2'd1;
			end
		end else if (ext_op_o != pi1_pkg::PI1_NOOP) begin
			ext_busy <= 1'b1;
			ext_wait <= 2'($urandom % 4);
			ext_resp <= {1'b0, ext_idx_o, ext_addr_o[27:0]};
		end
	end

	always @(negedge clk48mhz_i) begin
		ext_rdy_i  <= ext_busy && (ext_wait == 2'd0) && !ext_rdy_i;
		ext_data_i <= ext_busy ? ext_resp : '0;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// External unless the address falls in the device table or the default region
	function automatic bit routed_external(input logic [31:0] addr);
		logic [31:0] dt_base;
		logic [31:0] dflt_base;
		dt_base   = 32'(soc_map_pkg::REGION_SIZE[soc_map_pkg::S_SDCARD]);
		dflt_base = '0;
		for (int k = 0; k < int'(soc_map_pkg::S_INVALIDDEV); k++) begin
			dflt_base = dflt_base + 32'(soc_map_pkg::REGION_SIZE[k]);
		end
		return addr < dflt_base &&
			!(addr >= dt_base &&
			addr < dt_base + 32'(soc_map_pkg::REGION_SIZE[soc_map_pkg::S_DEVTBL]));
	endfunction

	// Starts on a falling edge and returns on the one after the transfer
	task automatic bus_xfer(input pi1_pkg::pi1_op_t op, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [31:0] exp, output logic [31:0] rdata);
		bit ext_exp;
		ext_exp = routed_external(addr);
		op_i    = op;
		addr_i  = addr[pi1_pkg::ADDRBITSZ-1:0];
		data_i  = wdata;
		#1;
		while (!rdy_o) begin
			@(negedge clk48mhz_i);
			#1;
		end
		rdata = data_o;
		// Routing is visible on the external port while the request is held
		if (ext_exp) begin
			check("ext_op_o", 32'(ext_op_o), 32'(op));
			check("ext_idx_o", 32'(ext_idx_o), 32'(exp[31:28]));
			check("ext_addr_o", 32'(ext_addr_o), 32'(exp[27:0]));
			check("ext_data_o", ext_data_o, wdata);
			check("ext_sel_o", 32'(ext_sel_o), 32'(sel_i));
		end else begin
			check("ext_op_o", 32'(ext_op_o), 32'(pi1_pkg::PI1_NOOP));
		end
		@(negedge clk48mhz_i);
		op_i = pi1_pkg::PI1_NOOP;
	endtask

	// Falling edges until sys_rst_o is seen low
	task automatic count_reset(output int n);
		n = 0;
		do begin
			@(negedge clk48mhz_i);
			n++;
		end while (sys_rst_o);
	endtask

	task automatic run_step(input int idx);
		logic [31:0] kind;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] exp;
		logic [31:0] rdata;
		int          n;
		kind  = steps[4*idx];
		addr  = steps[4*idx+1];
		wdata = steps[4*idx+2];
		exp   = steps[4*idx+3];
		case (kind)
			32'h0: begin
				bus_xfer(pi1_pkg::PI1_RD, addr, wdata, exp, rdata);
				check("data_o", rdata, exp);
			end
			32'h1: bus_xfer(pi1_pkg::PI1_WR, addr, wdata, exp, rdata);
			32'h2: begin
				bus_xfer(pi1_pkg::PI1_RW, addr, wdata, exp, rdata);
				check("data_o", rdata, exp);
			end
			32'h3: begin
				rst_p = 1'b1;
				repeat (2) @(negedge clk48mhz_i);
				rst_p = 1'b0;
				count_reset(n);
				check("sys_rst_o cycles", n, exp);
			end
			32'h4: begin
				pll_locked_i = 1'b0;
				repeat (wdata) begin
					@(negedge clk48mhz_i);
					check("sys_rst_o", 32'(sys_rst_o), 32'h1);
				end
				pll_locked_i = 1'b1;
				count_reset(n);
				check("sys_rst_o cycles", n, exp);
			end
			32'h5: begin
				count_reset(n);
				check("sys_rst_o cycles", n, exp);
			end
			32'h6: begin
				repeat (wdata) begin
					@(negedge clk48mhz_i);
					check("sys_rst_o", 32'(sys_rst_o), 32'h1);
				end
			end
			default: begin
				$display("Step %0d has an unknown kind %h", idx, kind);
				errors++;
			end
		endcase
	endtask

	initial begin
		void'($urandom(32'hd70c9ab0));
		rst_p        = 1'b1;
		pll_locked_i = 1'b1;
		cpu_rst_i    = 1'b0;
		op_i         = pi1_pkg::PI1_NOOP;
		addr_i       = '0;
		data_i       = '0;
		sel_i        = '1;
		errors       = 0;
		foreach (steps[i]) begin
			steps[i] = '1;
		end
		$readmemh("testbench/sysctl_tests.txt", steps);
		nsteps = 0;
		while (nsteps < MAX_STEPS && steps[4*nsteps] != 32'hffffffff) begin
			nsteps++;
		end
		if (nsteps == 0) begin
			$display("No test steps were read from the data file");
			errors++;
		end
		loaded = 1'b1;
		repeat (2) @(negedge clk48mhz_i);
		rst_p = 1'b0;
		for (int i = 0; i < nsteps; i++) begin
			run_step(i);
		end
		$display("Ran %0d steps, %0d errors", nsteps, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Bound from the step count so a hung handshake cannot stall the run
	initial begin
		int limit;
		wait (loaded);
		limit = (nsteps + 1) * STEP_CYCLES;
		repeat (limit) @(posedge clk48mhz_i);
		$display("Timeout: the steps did not finish within %0d cycles", limit);
		$display("TB FAILED");
		$finish;
	end

endmodule

/* testbench/sysctl_tests.txt */
// Columns (hex): kind address data expected
// Kinds: 0 read, 1 write, 2 swap, 3 button reset, 4 pll drop, 5 reset cycles, 6 held high
5 0 0 f
0 80 0 10004
0 81 0 80
0 82 0 7
0 83 0 40
0 86 0 10005
0 89 0 8000000
0 8c 0 0
0 8f 0 400
0 91 0 0
0 80014cc 0 0
0 3fffffff 0 0
1 80014d0 1234 0
0 80014d0 0 0
0 10 0 10
0 c5 0 20000005
0 cb 0 30000003
0 100 0 40000034
0 80000cb 0 47ffffff
1 80000cc 55 50000000
0 80014cb 0 600003ff
1 90 3 0
2 90 0 3
0 90 0 0
// Lock loss does not reload the hold counter
4 0 8 1
1 90 2 0
// Two cycles for the request to clear, then the 15-cycle hold
5 0 0 11
0 90 0 0
1 90 1 0
6 0 1e 0
3 0 0 f
0 90 0 0
0 80 0 10004

/* verilog.f */
verilog/pi1_pkg.sv
verilog/soc_map_pkg.sv
verilog/pi1_interconnect.sv
verilog/devtbl.sv
verilog/rst_sequencer.sv
verilog/sysctl_top.sv
testbench/sysctl_props.sv
testbench/sysctl_tb.sv

/* verilog/devtbl.sv */
/* Device table slave, one cycle latency with a single-cycle rdy.
   Only bits 1:0 of the reset-request word exist, written when sel bit 0 is set. */
`timescale 1ns/1ps

module devtbl (
	input  logic                          clk48mhz_i,
	input  logic                          rst_i,
	input  pi1_pkg::pi1_op_t              op_i,
	input  logic [pi1_pkg::ADDRBITSZ-1:0] addr_i,
	input  logic [pi1_pkg::ARCHBITSZ-1:0] data_i,
	input  logic [pi1_pkg::SELBITSZ-1:0]  sel_i,
	output logic [pi1_pkg::ARCHBITSZ-1:0] data_o,
	output logic                          rdy_o,
	output logic                          rst0_o,
	output logic                          rst1_o
);

	localparam int TBL_WORDS = 2 * soc_map_pkg::SLAVECOUNT;

	pi1_pkg::devtbl_word_u                 tbl_word;
	logic [pi1_pkg::ARCHBITSZ-1:0]         rd_word;
	logic [soc_map_pkg::SLAVEIDXBITSZ-1:0] tbl_idx;
	logic                                  is_rstreg;
	logic                                  accept;
	logic                                  wr_en;
	logic                                  rdy_r;
	logic [pi1_pkg::ARCHBITSZ-1:0]         data_r;
	// {rst1, rst0}
	logic [1:0]                            rst_req_r;

	assign tbl_idx   = addr_i[soc_map_pkg::SLAVEIDXBITSZ:1];
	assign is_rstreg = (addr_i == pi1_pkg::ADDRBITSZ'(soc_map_pkg::DEVTBL_RSTREG_OFS));

	// Even offsets give id and irq flag, odd ones the region size
	always_comb begin
		tbl_word = '0;
		if (addr_i[0]) begin
			tbl_word.mapsz.size = soc_map_pkg::REGION_SIZE[tbl_idx];
		end else begin
			tbl_word.info.id      = soc_map_pkg::DEVICE_ID[tbl_idx];
			tbl_word.info.useintr = soc_map_pkg::USEINTR[tbl_idx];
		end
	end

	always_comb begin
		if (addr_i < pi1_pkg::ADDRBITSZ'(TBL_WORDS)) begin
			rd_word = tbl_word;
		end else if (is_rstreg) begin
			rd_word = {{(pi1_pkg::ARCHBITSZ-2){1'b0}}, rst_req_r};
		end else begin
			rd_word = '0;
		end
	end

	// The master still holds the op during rdy, so that cycle is not a new request
	assign accept = (op_i != pi1_pkg::PI1_NOOP) && !rdy_r;
	assign wr_en  = rdy_r && is_rstreg && sel_i[0] &&
		(op_i == pi1_pkg::PI1_WR || op_i == pi1_pkg::PI1_RW);

	always_ff @(posedge clk48mhz_i) begin
		if (rst_i) begin
			rdy_r     <= 1'b0;
			rst_req_r <= 2'b00;
		end else begin
			rdy_r <= accept;
			if (wr_en) begin
				rst_req_r <= data_i[1:0];
			end
		end
	end

	// Read data is taken before the write, so a swap returns the old word
	always_ff @(posedge clk48mhz_i) begin
		if (accept) begin
			data_r <= rd_word;
		end
	end

	assign data_o = data_r;
	assign rdy_o  = rdy_r;
	assign rst0_o = rst_req_r[0];
	assign rst1_o = rst_req_r[1];

endmodule

/* verilog/pi1_interconnect.sv */
/* Single-master PI1 address decoder. Requests must be held until rdy_o.
   The invalid region and addresses past the map get zero data and same-cycle rdy. */
`timescale 1ns/1ps

module pi1_interconnect (
	input  logic                                  clk48mhz_i,
	input  logic                                  rst_i,

	// Master side
	input  pi1_pkg::pi1_op_t                      op_i,
	input  logic [pi1_pkg::ADDRBITSZ-1:0]         addr_i,
	input  logic [pi1_pkg::ARCHBITSZ-1:0]         data_i,
	input  logic [pi1_pkg::SELBITSZ-1:0]          sel_i,
	output logic [pi1_pkg::ARCHBITSZ-1:0]         data_o,
	output logic                                  rdy_o,

	// Device table
	output pi1_pkg::pi1_op_t                      dt_op_o,
	output logic [pi1_pkg::ADDRBITSZ-1:0]         dt_addr_o,
	output logic [pi1_pkg::ARCHBITSZ-1:0]         dt_data_o,
	output logic [pi1_pkg::SELBITSZ-1:0]          dt_sel_o,
	input  logic [pi1_pkg::ARCHBITSZ-1:0]         dt_data_i,
	input  logic                                  dt_rdy_i,

	// External slaves
	output pi1_pkg::pi1_op_t                      ext_op_o,
	output logic [soc_map_pkg::SLAVEIDXBITSZ-1:0] ext_idx_o,
	output logic [pi1_pkg::ADDRBITSZ-1:0]         ext_addr_o,
	output logic [pi1_pkg::ARCHBITSZ-1:0]         ext_data_o,
	output logic [pi1_pkg::SELBITSZ-1:0]          ext_sel_o,
	input  logic [pi1_pkg::ARCHBITSZ-1:0]         ext_data_i,
	input  logic                                  ext_rdy_i
);

	logic [soc_map_pkg::SLAVEIDXBITSZ-1:0] slv_idx;
	logic [pi1_pkg::ADDRBITSZ-1:0]         slv_ofs;
	logic                                  hit_dt;
	logic                                  hit_ext;
	logic                                  bus_live_r;
	logic                                  bus_en;

	// No slave is handed a request until the cycle after reset ends
	always_ff @(posedge clk48mhz_i) begin
		if (rst_i) begin
			bus_live_r <= 1'b0;
		end else begin
			bus_live_r <= 1'b1;
		end
	end

	// A reset that starts mid-request cuts the op off at once
	assign bus_en = bus_live_r && !rst_i;

	// Walk the region bases, one extra bit so the sum past the map cannot wrap
	always_comb begin : decode
		logic [pi1_pkg::ADDRBITSZ:0] base;
		base    = '0;
		slv_idx = soc_map_pkg::S_INVALIDDEV;
		slv_ofs = '0;
		for (int k = 0; k < soc_map_pkg::SLAVECOUNT; k++) begin
			if ({1'b0, addr_i} >= base &&
				{1'b0, addr_i} < base + {1'b0, soc_map_pkg::REGION_SIZE[k]}) begin
				slv_idx = soc_map_pkg::SLAVEIDXBITSZ'(k);
				slv_ofs = addr_i - base[pi1_pkg::ADDRBITSZ-1:0];
			end
			base = base + {1'b0, soc_map_pkg::REGION_SIZE[k]};
		end
	end

	assign hit_dt  = (slv_idx == soc_map_pkg::S_DEVTBL);
	assign hit_ext = !hit_dt && (slv_idx != soc_map_pkg::S_INVALIDDEV);

	// Only the selected target sees the op
	assign dt_op_o   = (bus_en && hit_dt) ? op_i : pi1_pkg::PI1_NOOP;
	assign dt_addr_o = slv_ofs;
	assign dt_data_o = data_i;
	assign dt_sel_o  = sel_i;

	assign ext_op_o   = (bus_en && hit_ext) ? op_i : pi1_pkg::PI1_NOOP;
	assign ext_idx_o  = slv_idx;
	assign ext_addr_o = slv_ofs;
	assign ext_data_o = data_i;
	assign ext_sel_o  = sel_i;

	// Return path; the default slave answers on its own
	always_comb begin
		if (hit_dt) begin
			data_o = dt_data_i;
			rdy_o  = dt_rdy_i;
		end else if (hit_ext) begin
			data_o = ext_data_i;
			rdy_o  = ext_rdy_i;
		end else begin
			data_o = '0;
			rdy_o  = 1'b1;
		end
	end

endmodule

/* verilog/pi1_pkg.sv */
/* PI1 bus encodings and widths. Word addresses only, so byte lanes go through sel.
   The device-table word has two layouts, and the word address parity picks one. */

package pi1_pkg;

	localparam int ARCHBITSZ  = 32;
	localparam int ADDRBITSZ  = 30;
	localparam int SELBITSZ   = ARCHBITSZ / 8;
	localparam int DEVIDBITSZ = 16;

	// Bus operation, held by the master until rdy
	typedef enum logic [1:0] {
		PI1_NOOP = 2'b00,
		PI1_WR   = 2'b01,
		PI1_RD   = 2'b10,
		// Swap: old word returned, new word written
		PI1_RW   = 2'b11
	} pi1_op_t;

	// Device-table entry
	// Even word: info view, odd word: mapsz view
	typedef union packed {
		struct packed {
			logic [ARCHBITSZ-DEVIDBITSZ-2:0] rsvd;
			logic                            useintr;
			logic [DEVIDBITSZ-1:0]           id;
		} info;
		struct packed {
			logic [ARCHBITSZ-ADDRBITSZ-1:0] rsvd;
			// Region size in words
			logic [ADDRBITSZ-1:0]           size;
		} mapsz;
	} devtbl_word_u;

endpackage

/* verilog/rst_sequencer.sv */
/* System reset, held 2^RST_HOLD_BITS-1 cycles after the last cause goes away.
   Power-off holds reset until rst_p; loss of PLL lock asserts it directly. */
`timescale 1ns/1ps

module rst_sequencer #(
	parameter int RST_HOLD_BITS = 16
) (
	input  logic clk48mhz_i,
	input  logic rst_p,
	input  logic pll_locked_i,
	input  logic cpu_rst_i,
	input  logic rst0_i,
	input  logic rst1_i,
	output logic sys_rst_o
);

	logic                     warm_rst;
	logic                     pwr_off;
	logic [RST_HOLD_BITS-1:0] hold_cnt;
	logic                     pwr_off_r;

	// Request decode from the device table
	assign warm_rst = rst1_i && !rst0_i;
	assign pwr_off  = rst0_i && !rst1_i;

	// Reload while any cause is present, then count down to zero
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p || cpu_rst_i || warm_rst) begin
			hold_cnt <= '1;
		end else if (|hold_cnt) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			pwr_off_r <= 1'b0;
		end else if (pwr_off) begin
			pwr_off_r <= 1'b1;
		end
	end

	assign sys_rst_o = !pll_locked_i || pwr_off_r || (|hold_cnt);

endmodule

/* verilog/soc_map_pkg.sv */
/* Physical address map of the peripheral bus, regions back to back from word 0.
   Anything past the last region belongs to the invalid device. */

package soc_map_pkg;

	localparam int SLAVECOUNT    = 8;
	localparam int SLAVEIDXBITSZ = 3;

	// Slave indices in region order
	localparam logic [SLAVEIDXBITSZ-1:0] S_SDCARD     = 3'd0;
	localparam logic [SLAVEIDXBITSZ-1:0] S_DEVTBL     = 3'd1;
	localparam logic [SLAVEIDXBITSZ-1:0] S_INTCTRL    = 3'd2;
	localparam logic [SLAVEIDXBITSZ-1:0] S_SERIAL     = 3'd3;
	localparam logic [SLAVEIDXBITSZ-1:0] S_RAM        = 3'd4;
	localparam logic [SLAVEIDXBITSZ-1:0] S_RAMCTRL    = 3'd5;
	localparam logic [SLAVEIDXBITSZ-1:0] S_BOOTLDR    = 3'd6;
	localparam logic [SLAVEIDXBITSZ-1:0] S_INVALIDDEV = 3'd7;

	// Region sizes in words
	localparam logic [pi1_pkg::ADDRBITSZ-1:0] REGION_SIZE [SLAVECOUNT] = '{
		S_SDCARD:     30'h80,
		S_DEVTBL:     30'h40,
		S_INTCTRL:    30'h8,
		S_SERIAL:     30'h4,
		// 512MB of DRAM
		S_RAM:        30'h8000000,
		S_RAMCTRL:    30'h1000,
		S_BOOTLDR:    30'h400,
		S_INVALIDDEV: 30'h400
	};

	// Device IDs reported to software
	localparam logic [pi1_pkg::DEVIDBITSZ-1:0] DEVICE_ID [SLAVECOUNT] = '{
		S_SDCARD:  16'd4,
		S_DEVTBL:  16'd7,
		S_INTCTRL: 16'd3,
		S_SERIAL:  16'd5,
		S_RAM:     16'd1,
		default:   16'd0
	};

	// Devices that raise interrupts
	localparam logic USEINTR [SLAVECOUNT] = '{
		S_SDCARD: 1'b1,
		S_SERIAL: 1'b1,
		default:  1'b0
	};

	// Reset-request register, right after the 2*SLAVECOUNT table words
	localparam int DEVTBL_RSTREG_OFS = 16;

endpackage

/* verilog/sysctl_top.sv */
/* System controller: reset sequencing, address decode and the device table.
   Slaves other than the device table are reached through the ext_* port. */
`timescale 1ns/1ps

module sysctl_top #(
	parameter int RST_HOLD_BITS = 16
) (
	input  logic                                  clk48mhz_i,
	input  logic                                  rst_p,
	input  logic                                  pll_locked_i,
	input  logic                                  cpu_rst_i,

	// Master port
	input  pi1_pkg::pi1_op_t                      op_i,
	input  logic [pi1_pkg::ADDRBITSZ-1:0]         addr_i,
	input  logic [pi1_pkg::ARCHBITSZ-1:0]         data_i,
	input  logic [pi1_pkg::SELBITSZ-1:0]          sel_i,
	output logic [pi1_pkg::ARCHBITSZ-1:0]         data_o,
	output logic                                  rdy_o,

	// External slave port
	output pi1_pkg::pi1_op_t                      ext_op_o,
	output logic [soc_map_pkg::SLAVEIDXBITSZ-1:0] ext_idx_o,
	output logic [pi1_pkg::ADDRBITSZ-1:0]         ext_addr_o,
	output logic [pi1_pkg::ARCHBITSZ-1:0]         ext_data_o,
	output logic [pi1_pkg::SELBITSZ-1:0]          ext_sel_o,
	input  logic [pi1_pkg::ARCHBITSZ-1:0]         ext_data_i,
	input  logic                                  ext_rdy_i,

	output logic                                  sys_rst_o
);

	pi1_pkg::pi1_op_t              dt_op;
	logic [pi1_pkg::ADDRBITSZ-1:0] dt_addr;
	logic [pi1_pkg::ARCHBITSZ-1:0] dt_wdata;
	logic [pi1_pkg::SELBITSZ-1:0]  dt_sel;
	logic [pi1_pkg::ARCHBITSZ-1:0] dt_rdata;
	logic                          dt_rdy;
	logic                          dt_rst0;
	logic                          dt_rst1;

	pi1_interconnect u_ic (
		.clk48mhz_i (clk48mhz_i),
		.rst_i      (sys_rst_o),
		.op_i       (op_i),
		.addr_i     (addr_i),
		.data_i     (data_i),
		.sel_i      (sel_i),
		.data_o     (data_o),
		.rdy_o      (rdy_o),
		.dt_op_o    (dt_op),
		.dt_addr_o  (dt_addr),
		.dt_data_o  (dt_wdata),
		.dt_sel_o   (dt_sel),
		.dt_data_i  (dt_rdata),
		.dt_rdy_i   (dt_rdy),
		.ext_op_o   (ext_op_o),
		.ext_idx_o  (ext_idx_o),
		.ext_addr_o (ext_addr_o),
		.ext_data_o (ext_data_o),
		.ext_sel_o  (ext_sel_o),
		.ext_data_i (ext_data_i),
		.ext_rdy_i  (ext_rdy_i)
	);

	// Device table is itself reset by the system reset, which clears a warm request
	devtbl u_devtbl (
		.clk48mhz_i (clk48mhz_i),
		.rst_i      (sys_rst_o),
		.op_i       (dt_op),
		.addr_i     (dt_addr),
		.data_i     (dt_wdata),
		.sel_i      (dt_sel),
		.data_o     (dt_rdata),
		.rdy_o      (dt_rdy),
		.rst0_o     (dt_rst0),
		.rst1_o     (dt_rst1)
	);

	rst_sequencer #(
		.RST_HOLD_BITS (RST_HOLD_BITS)
	) u_rst_seq (
		.clk48mhz_i   (clk48mhz_i),
		.rst_p        (rst_p),
		.pll_locked_i (pll_locked_i),
		.cpu_rst_i    (cpu_rst_i),
		.rst0_i       (dt_rst0),
		.rst1_i       (dt_rst1),
		.sys_rst_o    (sys_rst_o)
	);

endmodule
